// ==== common/bus_pkg.sv ====
// Bus widths, slave indices and the address map of the router.
// Each slave owns one 64 KiB region; a mask keeps the upper 16 address bits.
// Regions must not overlap, so the decoder select stays one-hot.
// Slave index sets the bit position in select and write-enable vectors.

package bus_pkg;

    localparam int ADDR_WIDTH  = 32;        // byte address
    localparam int DATA_WIDTH  = 32;        // one bus word
    localparam int SLAVE_COUNT = 3;         // slaves behind the router

    // slave indices
    localparam int SLV_RAM   = 0;
    localparam int SLV_GPIO  = 1;
    localparam int SLV_TIMER = 2;

    // base addresses, index 0 is the rightmost entry
    localparam logic [SLAVE_COUNT-1:0][ADDR_WIDTH-1:0] SLAVE_BASE = {
        32'h0002_0000,                      // timer
        32'h0001_0000,                      // gpio
        32'h0000_0000                       // ram
    };

    // region masks, same order as SLAVE_BASE
    localparam logic [SLAVE_COUNT-1:0][ADDR_WIDTH-1:0] SLAVE_MASK = {
        32'hFFFF_0000,                      // timer, 64 KiB
        32'hFFFF_0000,                      // gpio, 64 KiB
        32'hFFFF_0000                       // ram, 64 KiB
    };

endpackage : bus_pkg

// ==== common/periph_pkg.sv ====
// Register offsets and sizes of the peripherals on the data bus.
// Offsets are byte offsets inside a slave region, compared on the low 16 bits.
// RAM is word addressed on bits 9..2, higher offsets in its region alias.

package periph_pkg;

    localparam int RAM_DEPTH     = 256;               // words
    localparam int RAM_AW        = $clog2(RAM_DEPTH); // word index bits
    localparam int GPIO_WIDTH    = 8;                 // pins
    localparam int REG_OFS_WIDTH = 16;                // offset bits in a region

    // gpio registers
    localparam logic [REG_OFS_WIDTH-1:0] GPIO_OUT_OFS = 16'h0000;  // r/w
    localparam logic [REG_OFS_WIDTH-1:0] GPIO_IN_OFS  = 16'h0004;  // ro, synced pins

    // timer registers
    localparam logic [REG_OFS_WIDTH-1:0] TMR_COUNT_OFS  = 16'h0000; // r/w counter
    localparam logic [REG_OFS_WIDTH-1:0] TMR_CMP_OFS    = 16'h0004; // r/w compare
    localparam logic [REG_OFS_WIDTH-1:0] TMR_STATUS_OFS = 16'h0008; // bit 0 match, w1c

endpackage : periph_pkg

// ==== design/bus_master_port.sv ====
// Bus master port between a four-phase req/ack master and the router.
// One request gives one single-cycle bus transfer, no retries or waits.
// ack, rdata and err show up two edges after req is first sampled.
// The master must hold addr, we and wdata until ack rises.

`timescale 1ns/10ps

module bus_master_port (
    input  logic                           clk,
    input  logic                           rst_n,
    // four-phase master side
    input  logic                           req,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                           we,
    input  logic [bus_pkg::DATA_WIDTH-1:0] wdata,
    output logic                           ack,
    output logic [bus_pkg::DATA_WIDTH-1:0] rdata,
    output logic                           err,
    // bus side
    output logic                           bus_valid,
    output logic [bus_pkg::ADDR_WIDTH-1:0] bus_addr,
    output logic                           bus_we,
    output logic [bus_pkg::DATA_WIDTH-1:0] bus_wdata,
    input  logic [bus_pkg::DATA_WIDTH-1:0] bus_rdata,
    input  logic                           bus_unmapped
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,                                  // waiting for req
        XFER = 2'd1,                                  // bus transfer cycle
        HOLD = 2'd2                                   // ack high until req drops
    } state_t;

    state_t state;

    assign bus_valid = (state == XFER);               // exactly one cycle per request

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
            err   <= 1'b0;
        end else begin
            case (state)
                IDLE: if (req) state <= XFER;         // cycle 0
                XFER: begin                           // cycle 1, response captured
                    state <= HOLD;
                    ack   <= 1'b1;
                    err   <= bus_unmapped;
                end
                HOLD: if (!req) begin                 // release seen
                    state <= IDLE;
                    ack   <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields and read data
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req) begin
            bus_addr  <= addr;
            bus_we    <= we;
            bus_wdata <= wdata;
        end
        if (state == XFER) rdata <= bus_rdata;        // held through HOLD
    end

    // a transfer never stretches past one cycle
    a_valid_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        bus_valid |=> !bus_valid);

    // ack only falls after the master has let go
    a_ack_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack);

endmodule : bus_master_port

// ==== design/bus_sys_top.sv ====
// Data bus subsystem top: master port, router, RAM, GPIO and timer.
// Single master, no wait-states; unmapped accesses return err and zero data.

`timescale 1ns/10ps

module bus_sys_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]    addr,
    input  logic                              we,
    input  logic [bus_pkg::DATA_WIDTH-1:0]    wdata,
    input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in,
    output logic                              ack,
    output logic [bus_pkg::DATA_WIDTH-1:0]    rdata,
    output logic                              err,
    output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out,
    output logic                              timer_irq
);

    // master port to router
    logic                           bus_valid;
    logic [bus_pkg::ADDR_WIDTH-1:0] bus_addr;
    logic                           bus_we;
    logic [bus_pkg::DATA_WIDTH-1:0] bus_wdata;
    logic [bus_pkg::DATA_WIDTH-1:0] bus_rdata;
    logic                           bus_unmapped;

    // router to slaves
    logic [bus_pkg::ADDR_WIDTH-1:0]                           slv_addr;
    logic [bus_pkg::DATA_WIDTH-1:0]                           slv_wdata;
    logic [bus_pkg::SLAVE_COUNT-1:0]                          slv_we;
    logic [bus_pkg::SLAVE_COUNT-1:0][bus_pkg::DATA_WIDTH-1:0] slv_rdata;

    bus_master_port bus_master_port_0 (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .req          ( req          ),
        .addr         ( addr         ),
        .we           ( we           ),
        .wdata        ( wdata        ),
        .ack          ( ack          ),
        .rdata        ( rdata        ),
        .err          ( err          ),
        .bus_valid    ( bus_valid    ),
        .bus_addr     ( bus_addr     ),
        .bus_we       ( bus_we       ),
        .bus_wdata    ( bus_wdata    ),
        .bus_rdata    ( bus_rdata    ),
        .bus_unmapped ( bus_unmapped )
    );

    nf_router nf_router_0 (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .bus_valid    ( bus_valid    ),
        .bus_addr     ( bus_addr     ),
        .bus_we       ( bus_we       ),
        .bus_wdata    ( bus_wdata    ),
        .bus_rdata    ( bus_rdata    ),
        .bus_unmapped ( bus_unmapped ),
        .slv_addr     ( slv_addr     ),
        .slv_wdata    ( slv_wdata    ),
        .slv_we       ( slv_we       ),
        .slv_rdata    ( slv_rdata    )
    );

    data_ram data_ram_0 (
        .clk   ( clk                         ),
        .rst_n ( rst_n                       ),
        .addr  ( slv_addr                    ),
        .we    ( slv_we[bus_pkg::SLV_RAM]    ),
        .wdata ( slv_wdata                   ),
        .rdata ( slv_rdata[bus_pkg::SLV_RAM] )
    );

    gpio_regs gpio_regs_0 (
        .clk      ( clk                          ),
        .rst_n    ( rst_n                        ),
        .addr     ( slv_addr                     ),
        .we       ( slv_we[bus_pkg::SLV_GPIO]    ),
        .wdata    ( slv_wdata                    ),
        .gpio_in  ( gpio_in                      ),
        .rdata    ( slv_rdata[bus_pkg::SLV_GPIO] ),
        .gpio_out ( gpio_out                     )
    );

    bus_timer bus_timer_0 (
        .clk       ( clk                           ),
        .rst_n     ( rst_n                         ),
        .addr      ( slv_addr                      ),
        .we        ( slv_we[bus_pkg::SLV_TIMER]    ),
        .wdata     ( slv_wdata                     ),
        .rdata     ( slv_rdata[bus_pkg::SLV_TIMER] ),
        .timer_irq ( timer_irq                     )
    );

endmodule : bus_sys_top

// ==== design/bus_timer.sv ====
// Timer slave with a free-running counter and one compare register.
// Match sets a sticky status bit that drives timer_irq; write 1 to bit 0 to clear.
// A match in the same cycle as the clear wins, so no event is lost.
// Compare comes up all ones, far from the counter start value.

`timescale 1ns/10ps

module bus_timer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                           we,
    input  logic [bus_pkg::DATA_WIDTH-1:0] wdata,
    output logic [bus_pkg::DATA_WIDTH-1:0] rdata,
    output logic                           timer_irq
);

    logic [periph_pkg::REG_OFS_WIDTH-1:0] ofs;        // offset inside region
    logic [bus_pkg::DATA_WIDTH-1:0]       count_q;    // free-running counter
    logic [bus_pkg::DATA_WIDTH-1:0]       cmp_q;      // compare value
    logic                                 status_q;   // sticky match
    logic                                 match;

    assign ofs       = addr[periph_pkg::REG_OFS_WIDTH-1:0];
    assign match     = (count_q == cmp_q);
    assign timer_irq = status_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q  <= '0;
            cmp_q    <= '1;
            status_q <= 1'b0;
        end else begin
            if (we && (ofs == periph_pkg::TMR_COUNT_OFS)) begin
                count_q <= wdata;                      // load beats increment
            end else begin
                count_q <= count_q + 1'b1;
            end
            if (we && (ofs == periph_pkg::TMR_CMP_OFS)) cmp_q <= wdata;
            if (match) begin
                status_q <= 1'b1;
            end else if (we && (ofs == periph_pkg::TMR_STATUS_OFS) && wdata[0]) begin
                status_q <= 1'b0;                      // w1c
            end
        end
    end

    // register read
    always_comb begin
        case (ofs)
            periph_pkg::TMR_COUNT_OFS:  rdata = count_q;
            periph_pkg::TMR_CMP_OFS:    rdata = cmp_q;
            periph_pkg::TMR_STATUS_OFS: rdata = bus_pkg::DATA_WIDTH'(status_q);
            default:                    rdata = '0;
        endcase
    end

    // irq only follows a real compare hit
    a_irq_cause : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(timer_irq) |-> $past(match));

endmodule : bus_timer

// ==== design/data_ram.sv ====
// Word RAM slave, RAM_DEPTH words, no byte enables.
// Indexed by address bits 9..2; higher region offsets alias, bits 1..0 ignored.
// Read is combinational, write lands on the clock edge.
// Contents come up undefined after power-on.

`timescale 1ns/10ps

module data_ram (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [bus_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                           we,
    input  logic [bus_pkg::DATA_WIDTH-1:0] wdata,
    output logic [bus_pkg::DATA_WIDTH-1:0] rdata
);

    logic [bus_pkg::DATA_WIDTH-1:0] mem [periph_pkg::RAM_DEPTH];  // storage array
    logic [periph_pkg::RAM_AW-1:0]  word_idx;                     // word index

    assign word_idx = addr[periph_pkg::RAM_AW+1:2];  // drop byte offset

    assign rdata = mem[word_idx];                      // async read

    always_ff @(posedge clk) begin
        if (rst_n && we) begin                         // writes ignored while in reset
            mem[word_idx] <= wdata;
        end
    end

endmodule : data_ram

// ==== design/gpio_regs.sv ====
// GPIO slave with GPIO_WIDTH output pins and GPIO_WIDTH input pins.
// Input pins pass a two-flop synchronizer before they can be read.
// Offsets other than OUT and IN read zero, writes to them are dropped.

`timescale 1ns/10ps

module gpio_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]    addr,
    input  logic                              we,
    input  logic [bus_pkg::DATA_WIDTH-1:0]    wdata,
    input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in,
    output logic [bus_pkg::DATA_WIDTH-1:0]    rdata,
    output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out
);

    logic [periph_pkg::REG_OFS_WIDTH-1:0] ofs;        // offset inside region
    logic [periph_pkg::GPIO_WIDTH-1:0]    in_meta;    // first sync stage
    logic [periph_pkg::GPIO_WIDTH-1:0]    in_sync;    // second sync stage, readable

    assign ofs = addr[periph_pkg::REG_OFS_WIDTH-1:0];

    // output register, low bits of the write word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (we && (ofs == periph_pkg::GPIO_OUT_OFS)) begin
            gpio_out <= wdata[periph_pkg::GPIO_WIDTH-1:0];
        end
    end

    // pin synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // register read, zero-extended
    always_comb begin
        case (ofs)
            periph_pkg::GPIO_OUT_OFS: rdata = bus_pkg::DATA_WIDTH'(gpio_out);
            periph_pkg::GPIO_IN_OFS:  rdata = bus_pkg::DATA_WIDTH'(in_sync);
            default:                  rdata = '0;
        endcase
    end

endmodule : gpio_regs

// ==== list.f ====
common/bus_pkg.sv
common/periph_pkg.sv
router/nf_router_dec.sv
router/nf_router.sv
design/bus_master_port.sv
design/data_ram.sv
design/gpio_regs.sv
design/bus_timer.sv
design/bus_sys_top.sv
+incdir+verification
verification/bus_sys_tb.sv

// ==== router/nf_router.sv ====
// Router between the bus master port and the slaves.
// Address and write data go to every slave; only the selected one gets we.
// Read data is an AND-OR over the one-hot select, zero when unmapped.
// clk and rst_n only clock the write-enable check.

`timescale 1ns/10ps

module nf_router (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    // master side
    input  logic                                                   bus_valid,
    input  logic [bus_pkg::ADDR_WIDTH-1:0]                         bus_addr,
    input  logic                                                   bus_we,
    input  logic [bus_pkg::DATA_WIDTH-1:0]                         bus_wdata,
    output logic [bus_pkg::DATA_WIDTH-1:0]                         bus_rdata,
    output logic                                                   bus_unmapped,
    // slave side
    output logic [bus_pkg::ADDR_WIDTH-1:0]                         slv_addr,
    output logic [bus_pkg::DATA_WIDTH-1:0]                         slv_wdata,
    output logic [bus_pkg::SLAVE_COUNT-1:0]                        slv_we,
    input  logic [bus_pkg::SLAVE_COUNT-1:0][bus_pkg::DATA_WIDTH-1:0] slv_rdata
);

    logic [bus_pkg::SLAVE_COUNT-1:0] slave_sel;       // one-hot or zero

    assign slv_addr  = bus_addr;                       // shared fan-out
    assign slv_wdata = bus_wdata;
    assign slv_we    = {bus_pkg::SLAVE_COUNT{bus_we & bus_valid}} & slave_sel;

    nf_router_dec nf_router_dec_0 (
        .addr      ( bus_addr     ),                   // master address
        .slave_sel ( slave_sel    ),                   // one-hot select
        .unmapped  ( bus_unmapped )                    // no slave claims it
    );

    // read data select
    always_comb begin
        bus_rdata = '0;                                // stays zero when unmapped
        for (int i = 0; i < bus_pkg::SLAVE_COUNT; i++) begin
            bus_rdata |= slv_rdata[i] & {bus_pkg::DATA_WIDTH{slave_sel[i]}};
        end
    end

    // only one slave may be written per transfer
    a_we_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(slv_we));

endmodule : nf_router

// ==== router/nf_router_dec.sv ====
// Address decoder for the router.
// Compares the masked address with each base of the address map.
// Select is one-hot as long as the map regions do not overlap.

`timescale 1ns/10ps

module nf_router_dec (
    input  logic [bus_pkg::ADDR_WIDTH-1:0]  addr,
    output logic [bus_pkg::SLAVE_COUNT-1:0] slave_sel,
    output logic                            unmapped
);

    always_comb begin
        for (int i = 0; i < bus_pkg::SLAVE_COUNT; i++) begin
            // region hit when the upper bits equal the base
            slave_sel[i] = ((addr & bus_pkg::SLAVE_MASK[i]) == bus_pkg::SLAVE_BASE[i]);
        end
    end

    assign unmapped = ~|slave_sel;                     // no region claims addr

endmodule : nf_router_dec

// ==== verification/bus_tb_tasks.svh ====
// Tasks included into the bus subsystem testbench module.
// They use the module's clock, DUT signals, counters and abort_run.
// Every task starts and ends on a rising clock edge.

`ifndef BUS_TB_TASKS_SVH
`define BUS_TB_TASKS_SVH

// one four-phase request, hold = extra cycles req stays up after ack
task automatic run_handshake(
    input  logic [bus_pkg::ADDR_WIDTH-1:0] a,
    input  logic                           w,
    input  logic [bus_pkg::DATA_WIDTH-1:0] d,
    input  int                             hold,
    output logic [bus_pkg::DATA_WIDTH-1:0] rd,
    output logic                           e
);
    int waited;
    req   <= 1'b1;                              // fields stable until ack
    addr  <= a;
    we    <= w;
    wdata <= d;
    waited = 0;
    @(posedge clk);
    while (!ack && (waited < ACK_TIMEOUT)) begin
        @(posedge clk);
        waited++;
    end
    if (!ack) begin
        $display("%s: no ack within %0d cycles of req", cur_test, ACK_TIMEOUT);
        abort_run();
    end
    rd = rdata;                                 // response held while req high
    e  = err;
    repeat (hold) @(posedge clk);
    req <= 1'b0;                                // release
    waited = 0;
    @(posedge clk);
    while (ack && (waited < ACK_TIMEOUT)) begin
        @(posedge clk);
        waited++;
    end
    if (ack) begin
        $display("%s: ack still high %0d cycles after req dropped", cur_test, ACK_TIMEOUT);
        abort_run();
    end
endtask

task automatic bus_write(
    input  logic [bus_pkg::ADDR_WIDTH-1:0] a,
    input  logic [bus_pkg::DATA_WIDTH-1:0] d,
    output logic [bus_pkg::DATA_WIDTH-1:0] rd,
    output logic                           e
);
    run_handshake(a, 1'b1, d, 0, rd, e);
endtask

task automatic bus_read(
    input  logic [bus_pkg::ADDR_WIDTH-1:0] a,
    output logic [bus_pkg::DATA_WIDTH-1:0] rd,
    output logic                           e
);
    run_handshake(a, 1'b0, '0, 0, rd, e);
endtask

task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
endtask

// one line per finished test
task automatic report_test();
    tests_run++;
    if (test_errs == 0) begin
        $display("%-10s ok", cur_test);
    end else begin
        tests_bad++;
        $display("%-10s %0d errors", cur_test, test_errs);
    end
endtask

`endif

// ==== verification/bus_sys_tb.sv ====
// Testbench for the data bus subsystem, one master, one transfer at a time.
// Values are checked by concurrent assertions on a capture channel.
// Random data and RAM addresses come from an LCG with a fixed seed.

`timescale 1ns/10ps

module bus_sys_tb;

    localparam int ACK_TIMEOUT = 20;                    // cycles per handshake wait
    localparam int IRQ_TIMEOUT = 200;
    localparam logic [31:0] GPIO_OUT_ADDR = 32'h0001_0000;
    localparam logic [31:0] GPIO_IN_ADDR  = 32'h0001_0004;
    localparam logic [31:0] TMR_COUNT_ADDR  = 32'h0002_0000;
    localparam logic [31:0] TMR_CMP_ADDR    = 32'h0002_0004;
    localparam logic [31:0] TMR_STATUS_ADDR = 32'h0002_0008;
    localparam logic [31:0] UNMAPPED_ADDR   = 32'h0005_0000;

    logic                              clk;
    logic                              rst_n;
    logic                              req;
    logic [bus_pkg::ADDR_WIDTH-1:0]    addr;
    logic                              we;
    logic [bus_pkg::DATA_WIDTH-1:0]    wdata;
    logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in;
    logic                              ack;
    logic [bus_pkg::DATA_WIDTH-1:0]    rdata;
    logic                              err;
    logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out;
    logic                              timer_irq;

    string                          chk_name;           // capture channel
    logic                           chk_pulse;
    logic [bus_pkg::DATA_WIDTH-1:0] chk_exp;
    logic [bus_pkg::DATA_WIDTH-1:0] chk_got;
    string cur_test;
    int    test_errs;
    int    err_total;
    int    tests_run;
    int    tests_bad;
    logic [31:0] lcg_state;
    logic [bus_pkg::DATA_WIDTH-1:0] ram_model [int];    // word index to last write

    always #4 clk = ~clk;                               // 8 ns

    bus_sys_top bus_sys_top_i (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .req       ( req       ),
        .addr      ( addr      ),
        .we        ( we        ),
        .wdata     ( wdata     ),
        .gpio_in   ( gpio_in   ),
        .ack       ( ack       ),
        .rdata     ( rdata     ),
        .err       ( err       ),
        .gpio_out  ( gpio_out  ),
        .timer_irq ( timer_irq )
    );

    a_value : assert property (@(posedge clk) disable iff (!rst_n)
        chk_pulse |-> (chk_got == chk_exp))
        else begin
            $display("ERROR %s: expected %h, actual %h", chk_name, chk_exp, chk_got);
            err_total++;
            test_errs++;
        end

    // response two cycles after req is sampled
    a_ack_delay : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> ##2 $rose(ack))
        else begin
            $display("%s: ack did not rise two cycles after req", cur_test);
            err_total++;
            test_errs++;
        end

    a_ack_steady : assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack)
        else begin
            $display("%s: ack dropped while req was still high", cur_test);
            err_total++;
            test_errs++;
        end

    a_ack_release : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |=> $fell(ack))
        else begin
            $display("%s: ack did not fall one cycle after req dropped", cur_test);
            err_total++;
            test_errs++;
        end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run();
        $display("test failed");
        $finish;
    endtask

    // values stay put one extra edge so the report shows them
    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        chk_name  <= {cur_test, " ", what};
        chk_exp   <= exp;
        chk_got   <= got;
        chk_pulse <= 1'b1;
        @(posedge clk);
        chk_pulse <= 1'b0;
        @(posedge clk);
    endtask

    `include "bus_tb_tasks.svh"

    initial begin
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] rd2;
        logic        e;
        logic [31:0] ram_addr [16];
        int          waited;
        clk = 1'b0;
        rst_n = 1'b0;
        req = 1'b0;
        addr = '0;
        we = 1'b0;
        wdata = '0;
        gpio_in = '0;
        chk_pulse = 1'b0;
        chk_exp = '0;
        chk_got = '0;
        lcg_state = 32'h575a18ef;
        err_total = 0;
        tests_run = 0;
        tests_bad = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start_test("ram");
        for (int i = 0; i < 16; i++) begin
            v = lcg_next();
            ram_addr[i] = {22'd0, v[7:0], 2'b00};       // word aligned
            v = lcg_next();
            ram_model[int'(ram_addr[i][9:2])] = v;
            bus_write(ram_addr[i], v, rd, e);
            check_value("write err", 32'd0, {31'd0, e});
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(ram_addr[i], rd, e);
            check_value("read data", ram_model[int'(ram_addr[i][9:2])], rd);
            check_value("read err", 32'd0, {31'd0, e});
        end
        report_test();

        start_test("handshake");                        // req held past ack
        run_handshake(ram_addr[0], 1'b0, '0, 4, rd, e);
        check_value("held read", ram_model[int'(ram_addr[0][9:2])], rd);
        report_test();

        start_test("gpio");
        v = lcg_next();
        bus_write(GPIO_OUT_ADDR, v, rd, e);
        check_value("pins", {24'd0, v[7:0]}, {24'd0, gpio_out});
        bus_read(GPIO_OUT_ADDR, rd, e);
        check_value("out read", {24'd0, v[7:0]}, rd);
        v = lcg_next();
        gpio_in <= v[7:0];
        repeat (3) @(posedge clk);                      // synchronizer delay
        bus_read(GPIO_IN_ADDR, rd, e);
        check_value("in read", {24'd0, v[7:0]}, rd);
        report_test();

        start_test("unmapped");
        v = lcg_next();
        bus_write(32'h0, v, rd, e);
        ram_model[0] = v;
        bus_write(UNMAPPED_ADDR, lcg_next(), rd, e);
        check_value("write err", 32'd1, {31'd0, e});
        check_value("write data", 32'd0, rd);
        bus_read(UNMAPPED_ADDR, rd, e);
        check_value("read err", 32'd1, {31'd0, e});
        check_value("read data", 32'd0, rd);
        bus_read(32'h0, rd, e);
        check_value("ram word 0", ram_model[0], rd);
        report_test();

        start_test("timer");
        bus_read(TMR_COUNT_ADDR, rd, e);
        bus_read(TMR_COUNT_ADDR, rd2, e);
        check_value("count rising", 32'd1, {31'd0, rd2 > rd});
        bus_write(TMR_CMP_ADDR, rd2 + 32'd40, rd, e);
        waited = 0;
        while (!timer_irq && (waited < IRQ_TIMEOUT)) begin
            @(posedge clk);
            waited++;
        end
        if (!timer_irq) begin
            $display("timer_irq did not rise within %0d cycles", IRQ_TIMEOUT);
            abort_run();
        end
        bus_write(TMR_STATUS_ADDR, 32'd1, rd, e);       // w1c
        check_value("irq after clear", 32'd0, {31'd0, timer_irq});
        bus_read(TMR_STATUS_ADDR, rd, e);
        check_value("status", 32'd0, rd);
        report_test();

        start_test("isolation");                        // same offset, other slave
        v = lcg_next();
        bus_write(32'h0, v, rd, e);
        ram_model[0] = v;
        rd2 = lcg_next();
        bus_write(GPIO_OUT_ADDR, rd2, rd, e);
        bus_read(32'h0, rd, e);
        check_value("ram word 0", ram_model[0], rd);
        bus_write(32'h0, lcg_next(), rd, e);
        bus_read(GPIO_OUT_ADDR, rd, e);
        check_value("gpio out", {24'd0, rd2[7:0]}, rd);
        report_test();

        $display("tests run %0d, clean %0d, with errors %0d", tests_run,
                 tests_run - tests_bad, tests_bad);
        if (err_total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : bus_sys_tb
